// File: source/fetch_pkg.sv
////////////////////
// Shared types and constants for the fetch front end
// NOP words use the OR32 NOP opcode with marker immediates
// Error tag values must match the cache's tag encoding
////////////////////
`default_nettype none

package fetch_pkg;

	////////////////////
	// Widths with meaning
	////////////////////
	typedef logic [31:0] word_t;
	// Byte address, low two bits zero on every output
	typedef logic [31:0] addr_t;
	// Cache response tag, classifies errors
	typedef logic [3:0]  itag_t;

	////////////////////
	// Structs
	////////////////////
	// One cache port response, ack and err never high together
	typedef struct packed {
		word_t dat;
		logic  ack;
		logic  err;
		addr_t adr;
		itag_t tag;
	} ic_resp_t;

	// Fetch exception flags
	typedef struct packed {
		logic itlb_miss;
		logic immu_fault;
		logic bus_err;
	} fetch_exc_t;

	// What the decoder sees each cycle
	typedef struct packed {
		word_t      insn;
		addr_t      pc;
		fetch_exc_t exc;
	} fetch_out_t;

	////////////////////
	// Constants
	////////////////////
	// NOP with flush marker
	localparam word_t NOP_FLUSH = {6'b000101, 26'h041_0000};
	// NOP with stall marker
	localparam word_t NOP_STALL = {6'b000101, 26'h061_0000};

	// Error tags from the cache
	localparam itag_t ITAG_TE = 4'hd;
	localparam itag_t ITAG_PE = 4'hc;
	localparam itag_t ITAG_BE = 4'hb;

	// First fetch address after reset
	localparam addr_t RESET_VEC = 32'h0000_0100;
	// Sequential step, one word
	localparam addr_t PC_STEP   = 32'd4;

endpackage

`default_nettype wire

// File: source/pc_gen.sv
////////////////////
// Fetch address register
// Flush redirect wins over advance, advance over hold
// Redirect target is forced to word alignment
////////////////////
`default_nettype none

module pc_gen (
	input  logic             clk,
	input  logic             rst_n_i,
	// Pipeline controls
	input  logic             freeze_i,
	input  logic             flushpipe_i,
	input  fetch_pkg::addr_t redirect_pc_i,
	// From the fetch stage
	input  logic             if_stall_i,
	input  logic             refetch_i,
	// Current fetch address
	output fetch_pkg::addr_t fetch_adr_o
);

	import fetch_pkg::*;

	////////////////////
	// Next address
	////////////////////
	addr_t pc_q;
	addr_t pc_d;
	addr_t redirect_aligned;
	logic  advance;

	// Drop the byte offset of the target
	assign redirect_aligned = {redirect_pc_i[31:2], 2'b00};

	// Step only when a response was taken
	// and the pipeline is free to move on
	assign advance = !freeze_i & !if_stall_i & !refetch_i;

	always_comb begin
		// Default hold
		pc_d = pc_q;
		if (flushpipe_i) begin
			// Redirect has the highest priority
			pc_d = redirect_aligned;
		end else if (advance) begin
			pc_d = pc_q + PC_STEP;
		end
	end

	////////////////////
	// Register
	////////////////////
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc_q <= RESET_VEC;
		end else begin
			pc_q <= pc_d;
		end
	end

	// Straight from the register, never mid-update
	assign fetch_adr_o = pc_q;

endmodule

`default_nettype wire

// File: source/insn_fetch.sv
////////////////////
// Fetch stage, one instruction and its pc per cycle
// Holds at most one response under freeze
// Outputs are combinational from response and saved state
////////////////////
`default_nettype none

module insn_fetch (
	input  logic                  clk,
	input  logic                  rst_n_i,
	// Cache response and current address
	input  fetch_pkg::ic_resp_t   resp_i,
	input  fetch_pkg::addr_t      fetch_adr_i,
	// Pipeline controls
	input  logic                  freeze_i,
	input  logic                  flushpipe_i,
	input  logic                  no_more_dslot_i,
	input  logic                  rfe_i,
	// To decode
	output fetch_pkg::fetch_out_t fetch_o,
	output logic                  stall_o,
	output logic                  saving_o,
	// Back to pc_gen
	output logic                  refetch_o
);

	import fetch_pkg::*;

	logic       resp_present;
	logic       save_insn;
	logic       resp_match;
	logic       bypass;
	logic       bypass_q;
	logic       saved_q;
	fetch_out_t saved_dat_q;
	fetch_exc_t resp_exc;
	addr_t      cur_pc;

	assign resp_present = resp_i.ack | resp_i.err;
	// Save only the first response seen under freeze
	assign save_insn    = resp_present & freeze_i & !saved_q;
	assign saving_o     = save_insn & !flushpipe_i;
	assign cur_pc       = {fetch_adr_i[31:2], 2'b00};

	////////////////////
	// Bypass after flush
	////////////////////
	// Response for the redirect target ends the bypass
	assign resp_match = resp_present & (resp_i.adr == fetch_adr_i);
	assign bypass     = flushpipe_i | (bypass_q & !resp_match);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			bypass_q <= 1'b0;
		end else begin
			bypass_q <= bypass;
		end
	end

	////////////////////
	// Error tag decode
	////////////////////
	assign resp_exc.itlb_miss  = resp_i.err & (resp_i.tag == ITAG_TE);
	assign resp_exc.immu_fault = resp_i.err & (resp_i.tag == ITAG_PE);
	assign resp_exc.bus_err    = resp_i.err & (resp_i.tag == ITAG_BE);

	////////////////////
	// Saved response
	////////////////////
	// Flag, priority flush then save then release
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			saved_q <= 1'b0;
		end else if (flushpipe_i) begin
			saved_q <= 1'b0;
		end else if (save_insn) begin
			saved_q <= 1'b1;
		end else if (!freeze_i) begin
			saved_q <= 1'b0;
		end
	end

	// Word, address and flags, same priority
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			saved_dat_q.insn <= NOP_FLUSH;
			saved_dat_q.pc   <= '0;
			saved_dat_q.exc  <= '0;
		end else if (flushpipe_i) begin
			saved_dat_q.insn <= NOP_FLUSH;
			saved_dat_q.pc   <= '0;
			saved_dat_q.exc  <= '0;
		end else if (save_insn) begin
			// Errored fetch carries a NOP, flags say why
			saved_dat_q.insn <= resp_i.err ? NOP_FLUSH : resp_i.dat;
			saved_dat_q.pc   <= {resp_i.adr[31:2], 2'b00};
			saved_dat_q.exc  <= resp_exc;
		end else if (!freeze_i) begin
			saved_dat_q.insn <= NOP_FLUSH;
			saved_dat_q.pc   <= cur_pc;
			saved_dat_q.exc  <= '0;
		end
	end

	////////////////////
	// Outputs
	////////////////////
	always_comb begin
		if (no_more_dslot_i | rfe_i | bypass) begin
			fetch_o.insn = NOP_FLUSH;
		end else if (saved_q) begin
			fetch_o.insn = saved_dat_q.insn;
		end else if (resp_i.ack) begin
			fetch_o.insn = resp_i.dat;
		end else begin
			// Nothing to hand over this cycle
			fetch_o.insn = NOP_STALL;
		end
	end

	assign fetch_o.pc = saved_q ? saved_dat_q.pc : cur_pc;
	// No exceptions past the last delay slot
	assign fetch_o.exc = no_more_dslot_i ? '0 : (saved_q ? saved_dat_q.exc : resp_exc);

	assign stall_o   = !resp_present & !saved_q;
	// New ack while holding one, pc_gen must not step for it
	assign refetch_o = saved_q & resp_i.ack;

endmodule

`default_nettype wire

// File: source/fetch_top.sv
////////////////////
// Fetch front end, pc_gen plus insn_fetch
// Cache must not answer again while a response is held
////////////////////
`default_nettype none

module fetch_top (
	input  logic                  clk,
	input  logic                  rst_n_i,
	// Cache port
	output fetch_pkg::addr_t      icpu_adr_o,
	input  fetch_pkg::ic_resp_t   icpu_resp_i,
	// Pipeline controls
	input  logic                  freeze_i,
	input  logic                  flushpipe_i,
	input  fetch_pkg::addr_t      redirect_pc_i,
	input  logic                  no_more_dslot_i,
	input  logic                  rfe_i,
	// To decode
	output fetch_pkg::fetch_out_t fetch_o,
	output logic                  stall_o,
	output logic                  saving_o
);

	import fetch_pkg::*;

	// Current fetch address, shared by cache and fetch stage
	addr_t fetch_adr;
	logic  if_stall;
	logic  genpc_refetch;

	pc_gen u_pc_gen (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.freeze_i      (freeze_i),
		.flushpipe_i   (flushpipe_i),
		.redirect_pc_i (redirect_pc_i),
		.if_stall_i    (if_stall),
		.refetch_i     (genpc_refetch),
		.fetch_adr_o   (fetch_adr)
	);

	insn_fetch u_insn_fetch (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.resp_i          (icpu_resp_i),
		.fetch_adr_i     (fetch_adr),
		.freeze_i        (freeze_i),
		.flushpipe_i     (flushpipe_i),
		.no_more_dslot_i (no_more_dslot_i),
		.rfe_i           (rfe_i),
		.fetch_o         (fetch_o),
		.stall_o         (if_stall),
		.saving_o        (saving_o),
		.refetch_o       (genpc_refetch)
	);

	assign icpu_adr_o = fetch_adr;
	// Stall also goes out to the pipeline
	assign stall_o    = if_stall;

endmodule

`default_nettype wire

// File: tb/fetch_checker.sv
////////////////////
// Bound to insn_fetch, watches its saved flag and outputs
// Checks are idle while reset is low
////////////////////
`default_nettype none

module fetch_checker (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  fetch_pkg::ic_resp_t   resp_i,
	input  logic                  freeze_i,
	input  logic                  flushpipe_i,
	input  logic                  no_more_dslot_i,
	input  logic                  saved_i,
	input  fetch_pkg::fetch_exc_t exc_i,
	input  logic                  stall_i
);

	import fetch_pkg::*;

	logic resp_present;

	assign resp_present = resp_i.ack | resp_i.err;

	// Flush always drops a held response
	a_flush_clears: assert property (@(posedge clk) disable iff (!rst_n_i)
		flushpipe_i |=> !saved_i) else $error("saved flag survived a flush");

	// First response under freeze is held
	a_save_sets: assert property (@(posedge clk) disable iff (!rst_n_i)
		(resp_present & freeze_i & !saved_i & !flushpipe_i) |=> saved_i)
		else $error("response under freeze was not saved");

	// Release of freeze empties the save slot
	a_release_clears: assert property (@(posedge clk) disable iff (!rst_n_i)
		(!freeze_i & !flushpipe_i) |=> !saved_i) else $error("saved flag held after release");

	a_no_dslot_flags: assert property (@(posedge clk) disable iff (!rst_n_i)
		no_more_dslot_i |-> (exc_i == '0)) else $error("exception flag set past delay slot");

	a_stall_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
		stall_i |-> (!resp_present & !saved_i)) else $error("stall with response or saved word");

endmodule

bind insn_fetch fetch_checker u_fetch_checker (
	.clk             (clk),
	.rst_n_i         (rst_n_i),
	.resp_i          (resp_i),
	.freeze_i        (freeze_i),
	.flushpipe_i     (flushpipe_i),
	.no_more_dslot_i (no_more_dslot_i),
	.saved_i         (saved_q),
	.exc_i           (fetch_o.exc),
	.stall_i         (stall_o)
);

`default_nettype wire

// File: tb/fetch_top_tb.sv
////////////////////
// Fetch front end testbench, cache modelled as memory with 0 to 3 cycles latency
// Outputs sampled one time unit before the rising edge
////////////////////
`default_nettype none

module fetch_top_tb;

	import fetch_pkg::*;

	localparam int MAX_WAIT = 200;

	logic       clk, rst_n_i, freeze_i, flushpipe_i, no_more_dslot_i, rfe_i;
	logic       stall_o, saving_o, rand_freeze, inject_err, tb_saved, tb_bypass;
	addr_t      redirect_pc_i, icpu_adr_o, exp_pc, saved_pc;
	ic_resp_t   icpu_resp_i;
	fetch_out_t fetch_o;
	fetch_exc_t exp_exc;
	itag_t      inject_tag;
	word_t      saved_word;
	logic [31:0] lfsr;
	logic [1:0] lat;
	int         errors, timeouts, accepts, err_accepts, saves;

	fetch_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = !clk;
	end

	// Memory contents, a fixed mix of every address bit
	function automatic word_t mem_word(input addr_t a);
		return {a[7:0], a[31:8]} ^ 32'h1357_9bdf;
	endfunction

	// Galois LFSR, one step per bit taken
	function automatic logic take_bit();
		logic b;
		b = lfsr[0];
		lfsr = b ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
		return b;
	endfunction

	task automatic expect_true(input logic ok, input string msg);
		assert (ok) else begin
			errors++;
			$display("Mismatch at %0t: %s", $time, msg);
		end
	endtask

	// Cache port, one response per request, silent while a word is held
	task automatic cache_step();
		if (icpu_resp_i.ack | icpu_resp_i.err) begin
			icpu_resp_i = '0;
			lat = {take_bit(), take_bit()};
		end else if (!tb_saved) begin
			if (lat != 0) begin
				lat--;
			end else begin
				icpu_resp_i.adr = icpu_adr_o;
				if (inject_err) begin
					icpu_resp_i.err = 1'b1;
					icpu_resp_i.tag = inject_tag;
					inject_err = 1'b0;
				end else begin
					icpu_resp_i.ack = 1'b1;
					icpu_resp_i.dat = mem_word(icpu_adr_o);
				end
			end
		end
	endtask

	task automatic sample_and_check();
		logic resp, nop_forced;
		resp = icpu_resp_i.ack | icpu_resp_i.err;
		nop_forced = rfe_i | no_more_dslot_i | flushpipe_i | (tb_bypass & !resp);
		expect_true(icpu_adr_o == exp_pc, "icpu_adr_o off the fetch sequence");
		if (nop_forced) expect_true(fetch_o.insn == NOP_FLUSH, "insn not NOP_FLUSH");
		if (no_more_dslot_i) expect_true(fetch_o.exc == '0, "flags set under no_more_dslot");
		expect_true(stall_o == (!resp & !tb_saved), "stall_o wrong");
		if (stall_o & !nop_forced) expect_true(fetch_o.insn == NOP_STALL, "insn not NOP_STALL");
		expect_true(saving_o == (resp & freeze_i & !tb_saved & !flushpipe_i), "saving_o wrong");
		if (tb_saved) begin
			expect_true(fetch_o.pc == saved_pc, "held pc wrong");
			if (!nop_forced) expect_true(fetch_o.insn == saved_word, "held insn wrong");
		end
		// Accepted instruction, pc_gen steps at this edge
		if (!freeze_i & !flushpipe_i & (resp | tb_saved)) begin
			expect_true(fetch_o.pc == exp_pc, "accepted pc out of sequence");
			if (!tb_saved & !nop_forced & icpu_resp_i.ack)
				expect_true(fetch_o.insn == mem_word(exp_pc), "accepted insn wrong");
			if (!tb_saved & !no_more_dslot_i)
				expect_true(fetch_o.exc == (icpu_resp_i.err ? exp_exc : '0),
					"exception flags wrong");
			if (icpu_resp_i.err) err_accepts++;
			exp_pc += 4;
			accepts++;
		end
		// Reference state after the coming edge
		if (flushpipe_i) begin
			tb_saved = 1'b0;
			exp_pc = {redirect_pc_i[31:2], 2'b00};
		end else if (resp & freeze_i & !tb_saved) begin
			tb_saved = 1'b1;
			saved_pc = icpu_resp_i.adr;
			saved_word = icpu_resp_i.err ? NOP_FLUSH : icpu_resp_i.dat;
			saves++;
		end else if (!freeze_i) begin
			tb_saved = 1'b0;
		end
		tb_bypass = flushpipe_i | (tb_bypass & !resp);
	endtask

	task automatic step();
		@(negedge clk);
		freeze_i = rand_freeze ? take_bit() : 1'b0;
		cache_step();
		#3;
		sample_and_check();
	endtask

	task automatic wait_accepts(input int n);
		int target, cyc;
		target = accepts + n;
		cyc = 0;
		while (accepts < target && cyc < MAX_WAIT) begin
			step();
			cyc++;
		end
		if (accepts < target) begin
			timeouts++;
			$display("Timeout: fetch stopped delivering instructions");
		end
	endtask

	task automatic send_error(input itag_t tag, input fetch_exc_t flags);
		int target, cyc;
		inject_err = 1'b1;
		inject_tag = tag;
		exp_exc = flags;
		target = err_accepts + 1;
		cyc = 0;
		while (err_accepts < target && cyc < MAX_WAIT) begin
			step();
			cyc++;
		end
		if (err_accepts < target) begin
			timeouts++;
			$display("Timeout: error response was never taken");
		end
	endtask

	initial begin
		lfsr = 32'h8937;
		{freeze_i, flushpipe_i, no_more_dslot_i, rfe_i, rand_freeze, inject_err} = '0;
		{tb_saved, tb_bypass, lat} = '0;
		{errors, timeouts, accepts, err_accepts, saves} = '0;
		redirect_pc_i = '0;
		icpu_resp_i = '0;
		inject_tag = '0;
		exp_exc = '0;
		exp_pc = RESET_VEC;
		rst_n_i = 1'b0;
		repeat (4) @(negedge clk);
		rst_n_i = 1'b1;
		wait_accepts(20);
		rand_freeze = 1'b1;
		wait_accepts(30);
		rand_freeze = 1'b0;
		if (saves == 0) begin
			errors++;
			$display("No response arrived under freeze, save path not exercised");
		end
		// Flags in itlb_miss, immu_fault, bus_err order
		send_error(ITAG_TE, 3'b100);
		send_error(ITAG_PE, 3'b010);
		send_error(ITAG_BE, 3'b001);
		send_error(4'h3, 3'b000);
		no_more_dslot_i = 1'b1;
		send_error(ITAG_BE, 3'b001);
		wait_accepts(4);
		no_more_dslot_i = 1'b0;
		// Unaligned target, low bits must drop
		@(negedge clk);
		flushpipe_i = 1'b1;
		redirect_pc_i = 32'h0000_2006;
		cache_step();
		#3;
		sample_and_check();
		@(negedge clk);
		flushpipe_i = 1'b0;
		cache_step();
		#3;
		sample_and_check();
		wait_accepts(10);
		rfe_i = 1'b1;
		wait_accepts(8);
		rfe_i = 1'b0;
		wait_accepts(4);
		$display("errors=%0d timeouts=%0d accepted=%0d saves=%0d",
			errors, timeouts, accepts, saves);
		if (errors == 0 && timeouts == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: fetch_top.f
source/fetch_pkg.sv
source/pc_gen.sv
source/insn_fetch.sv
source/fetch_top.sv
tb/fetch_checker.sv
tb/fetch_top_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= fetch_top_tb
RTL_TOP   ?= fetch_top
FILELIST  ?= fetch_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^ALL CHECKS PASSED$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
